//--- logic/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

   // Word and address size of the load/store unit
   localparam int unsigned ADDR_WIDTH = 32;
   localparam int unsigned DATA_WIDTH = 32;
   localparam int unsigned BYTES_PER_WORD = DATA_WIDTH / 8;

   // Two ways, 16 sets of 16-byte lines
   localparam int unsigned NUM_WAYS = 2;
   localparam int unsigned OFFSET_WIDTH = 4;
   localparam int unsigned INDEX_WIDTH = 4;
   localparam int unsigned NUM_SETS = 2 ** INDEX_WIDTH;

   // Word select inside a line
   localparam int unsigned WORD_LSB = $clog2(BYTES_PER_WORD);
   localparam int unsigned WORD_SEL_WIDTH = OFFSET_WIDTH - WORD_LSB;
   localparam int unsigned WORDS_PER_LINE = 2 ** WORD_SEL_WIDTH;

   // Tag sits above index and offset
   localparam int unsigned TAG_LSB = OFFSET_WIDTH + INDEX_WIDTH;
   localparam int unsigned TAG_WIDTH = ADDR_WIDTH - TAG_LSB;

   // One history bit per pair of ways
   localparam int unsigned LRU_WIDTH = NUM_WAYS * (NUM_WAYS - 1) / 2;

   // Data RAM word address is index plus word select
   localparam int unsigned DATA_ADDR_WIDTH = INDEX_WIDTH + WORD_SEL_WIDTH;

endpackage

//--- logic/dcache_types_pkg.sv
package dcache_types_pkg;

   // One data word as stored in a way
   typedef logic [dcache_cfg_pkg::DATA_WIDTH-1:0] word_t;

   // Valid flag and tag of one way
   typedef struct packed {
      logic                                 valid;
      logic [dcache_cfg_pkg::TAG_WIDTH-1:0] tag;
   } tag_entry_t;

   // Full tag RAM entry of a set
   // LRU history on top, way 0 in the lowest bits
   typedef struct packed {
      logic [dcache_cfg_pkg::LRU_WIDTH-1:0]      lru;
      tag_entry_t [dcache_cfg_pkg::NUM_WAYS-1:0] way;
   } tag_line_t;

   // One bit per way, one-hot or zero
   typedef logic [dcache_cfg_pkg::NUM_WAYS-1:0] way_mask_t;

   // Controller states
   typedef enum logic [2:0] {
      INIT,
      IDLE,
      LOOKUP,
      REFILL,
      REPLAY,
      INVALIDATE
   } ctrl_state_t;

endpackage

//--- logic/dcache_sdp_ram.sv
module dcache_sdp_ram #(
   parameter type         payload_t  = logic [31:0],
   parameter int unsigned DEPTH_LOG2 = 4
) (
   input  logic                  clk,
   input  logic                  we_i,
   input  logic [DEPTH_LOG2-1:0] waddr_i,
   input  payload_t              wdata_i,
   input  logic [DEPTH_LOG2-1:0] raddr_i,
   output payload_t              rdata_o
);

   payload_t mem [2 ** DEPTH_LOG2];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // Registered read
   // Same-address write in this cycle shows up one read later
   always_ff @(posedge clk) begin
      rdata_o <= mem[raddr_i];
   end

endmodule

//--- logic/dcache_lookup.sv
module dcache_lookup (
   input  dcache_types_pkg::tag_line_t                        tag_line_i,
   input  dcache_types_pkg::word_t [dcache_cfg_pkg::NUM_WAYS-1:0] way_rdata_i,
   input  logic [dcache_cfg_pkg::TAG_WIDTH-1:0]               req_tag_i,
   input  dcache_types_pkg::word_t                            req_wdata_i,
   input  logic [dcache_cfg_pkg::BYTES_PER_WORD-1:0]          req_bsel_i,
   output logic                                               hit_o,
   output dcache_types_pkg::way_mask_t                        way_hit_o,
   output dcache_types_pkg::word_t                            rdata_o,
   output dcache_types_pkg::word_t                            merged_o
);

   import dcache_cfg_pkg::*;

   // Tag compare per way and AND-OR select of the hitting word
   always_comb begin
      way_hit_o = '0;
      rdata_o = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_hit_o[w] = tag_line_i.way[w].valid && (tag_line_i.way[w].tag == req_tag_i);
         if (way_hit_o[w]) begin
            rdata_o = rdata_o | way_rdata_i[w];
         end
      end
      // Refill never puts the same tag into two ways of a set
      if (!$isunknown(way_hit_o)) begin
         a_way_hit_onehot: assert ($onehot0(way_hit_o));
      end
   end

   assign hit_o = |way_hit_o;

   // Byte lane merge for write hits
   // Lanes not selected keep the cached byte
   always_comb begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         merged_o[8*b +: 8] = req_bsel_i[b] ? req_wdata_i[8*b +: 8] : rdata_o[8*b +: 8];
      end
   end

endmodule

//--- logic/dcache_lru.sv
module dcache_lru (
   input  logic [dcache_cfg_pkg::LRU_WIDTH-1:0] history_i,
   input  dcache_types_pkg::way_mask_t          access_i,
   output logic [dcache_cfg_pkg::LRU_WIDTH-1:0] history_o,
   output dcache_types_pkg::way_mask_t          victim_o
);

   import dcache_cfg_pkg::*;

   // Pairs (i, j) with i < j are numbered in loop order
   // Bit set means way i was used after way j
   always_comb begin
      int unsigned k;
      k = 0;
      history_o = history_i;
      // Every way starts as a candidate
      victim_o = '1;
      for (int i = 0; i < NUM_WAYS; i++) begin
         for (int j = i + 1; j < NUM_WAYS; j++) begin
            // Accessed way becomes the newer one of each of its pairs
            if (access_i[i]) begin
               history_o[k] = 1'b1;
            end
            if (access_i[j]) begin
               history_o[k] = 1'b0;
            end
            // The newer way of a pair cannot be the victim
            if (history_i[k]) begin
               victim_o[i] = 1'b0;
            end else begin
               victim_o[j] = 1'b0;
            end
            k++;
         end
      end
      // Holds for any history the controller writes back
      if (!$isunknown(history_i)) begin
         a_victim_onehot: assert ($onehot(victim_o));
      end
   end

endmodule

//--- logic/dcache_refill.sv
module dcache_refill (
   input  logic                                      clk,
   input  logic                                      rst,
   input  logic                                      start_i,
   input  logic [dcache_cfg_pkg::ADDR_WIDTH-1:0]     line_addr_i,
   output logic                                      mem_req_valid_o,
   input  logic                                      mem_req_ready_i,
   output logic [dcache_cfg_pkg::ADDR_WIDTH-1:0]     mem_req_addr_o,
   input  logic                                      mem_rvalid_i,
   input  dcache_types_pkg::word_t                   mem_rdata_i,
   output logic                                      beat_we_o,
   output logic [dcache_cfg_pkg::WORD_SEL_WIDTH-1:0] beat_word_o,
   output dcache_types_pkg::word_t                   beat_data_o,
   output logic                                      done_o
);

   import dcache_cfg_pkg::*;

   logic                      wait_beats_q;
   logic [WORD_SEL_WIDTH-1:0] beat_cnt_q;
   logic [ADDR_WIDTH-1:0]     line_addr_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         mem_req_valid_o <= 1'b0;
         wait_beats_q <= 1'b0;
         beat_cnt_q <= '0;
      end else begin
         // Request stays up until memory takes it
         if (start_i) begin
            mem_req_valid_o <= 1'b1;
         end else if (mem_req_valid_o && mem_req_ready_i) begin
            mem_req_valid_o <= 1'b0;
            wait_beats_q <= 1'b1;
         end
         // Counter wraps to zero after the last beat
         if (beat_we_o) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
         if (done_o) begin
            wait_beats_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start_i) begin
         line_addr_q <= line_addr_i;
      end
   end

   assign mem_req_addr_o = line_addr_q;

   // Beats come in word order, one strobe each
   assign beat_we_o = wait_beats_q && mem_rvalid_i;
   assign beat_word_o = beat_cnt_q;
   assign beat_data_o = mem_rdata_i;
   assign done_o = beat_we_o && (beat_cnt_q == WORD_SEL_WIDTH'(WORDS_PER_LINE - 1));

   // Memory only returns data for an accepted line request
   a_beat_expected: assert property (@(posedge clk) disable iff (rst)
      mem_rvalid_i |-> wait_beats_q);

endmodule

//--- logic/dcache_ctrl.sv
module dcache_ctrl (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic                                       req_valid_i,
   output logic                                       req_ready_o,
   input  logic                                       req_we_i,
   input  logic [dcache_cfg_pkg::ADDR_WIDTH-1:0]      req_addr_i,
   input  dcache_types_pkg::word_t                    req_wdata_i,
   input  logic [dcache_cfg_pkg::BYTES_PER_WORD-1:0]  req_bsel_i,
   input  logic                                       inv_valid_i,
   output logic                                       inv_ready_o,
   input  logic [dcache_cfg_pkg::INDEX_WIDTH-1:0]     inv_index_i,
   output logic                                       rsp_valid_o,
   input  logic                                       rsp_ready_i,
   input  logic                                       hit_i,
   input  dcache_types_pkg::way_mask_t                way_hit_i,
   input  dcache_types_pkg::way_mask_t                victim_i,
   input  dcache_types_pkg::tag_line_t                tag_line_i,
   input  logic [dcache_cfg_pkg::LRU_WIDTH-1:0]       lru_history_i,
   input  logic [dcache_cfg_pkg::LRU_WIDTH-1:0]       lru_next_i,
   output dcache_types_pkg::way_mask_t                lru_access_o,
   output logic [dcache_cfg_pkg::INDEX_WIDTH-1:0]     tag_raddr_o,
   output logic                                       tag_we_o,
   output logic [dcache_cfg_pkg::INDEX_WIDTH-1:0]     tag_waddr_o,
   output dcache_types_pkg::tag_line_t                tag_wdata_o,
   output logic [dcache_cfg_pkg::DATA_ADDR_WIDTH-1:0] data_raddr_o,
   output dcache_types_pkg::way_mask_t                data_we_o,
   output logic [dcache_cfg_pkg::DATA_ADDR_WIDTH-1:0] data_waddr_o,
   output dcache_types_pkg::word_t                    data_wdata_o,
   input  dcache_types_pkg::word_t                    merged_i,
   output logic                                       refill_start_o,
   output logic [dcache_cfg_pkg::ADDR_WIDTH-1:0]      refill_line_addr_o,
   input  logic                                       beat_we_i,
   input  logic [dcache_cfg_pkg::WORD_SEL_WIDTH-1:0]  beat_word_i,
   input  dcache_types_pkg::word_t                    beat_data_i,
   input  logic                                       refill_done_i,
   output logic [dcache_cfg_pkg::TAG_WIDTH-1:0]       req_tag_o,
   output dcache_types_pkg::word_t                    req_wdata_o,
   output logic [dcache_cfg_pkg::BYTES_PER_WORD-1:0]  req_bsel_o
);

   import dcache_cfg_pkg::*;
   import dcache_types_pkg::*;

   ctrl_state_t               state_q;
   ctrl_state_t               state_d;
   logic [INDEX_WIDTH-1:0]    init_idx_q;
   logic                      req_we_q;
   logic [ADDR_WIDTH-1:0]     req_addr_q;
   word_t                     req_wdata_q;
   logic [BYTES_PER_WORD-1:0] req_bsel_q;
   way_mask_t                 victim_q;
   tag_line_t                 saved_line_q;
   logic [INDEX_WIDTH-1:0]    req_index;

   assign req_index = req_addr_q[TAG_LSB-1:OFFSET_WIDTH];
   assign req_tag_o = req_addr_q[ADDR_WIDTH-1:TAG_LSB];
   assign req_wdata_o = req_wdata_q;
   assign req_bsel_o = req_bsel_q;

   // Invalidate wins over a request in IDLE
   assign inv_ready_o = (state_q == IDLE);
   assign req_ready_o = (state_q == IDLE) && !inv_valid_i;

   // Hits and all writes answer straight from LOOKUP
   assign rsp_valid_o = (state_q == LOOKUP) && (hit_i || req_we_q);
   // Only a read miss fetches a line
   assign refill_start_o = (state_q == LOOKUP) && !hit_i && !req_we_q;
   assign refill_line_addr_o = {req_addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

   // RAMs read the incoming address in IDLE, the held one otherwise
   // REPLAY rereads the set once the refilled line has landed
   assign tag_raddr_o = (state_q == IDLE) ? req_addr_i[TAG_LSB-1:OFFSET_WIDTH] : req_index;
   assign data_raddr_o = (state_q == IDLE) ? req_addr_i[TAG_LSB-1:WORD_LSB]
                                           : req_addr_q[TAG_LSB-1:WORD_LSB];

   always_comb begin
      state_d = state_q;
      case (state_q)
         INIT: begin
            if (init_idx_q == INDEX_WIDTH'(NUM_SETS - 1)) begin
               state_d = IDLE;
            end
         end
         IDLE: begin
            if (inv_valid_i) begin
               state_d = INVALIDATE;
            end else if (req_valid_i) begin
               state_d = LOOKUP;
            end
         end
         // One quiet cycle after a set is cleared
         INVALIDATE: state_d = IDLE;
         LOOKUP: begin
            if (rsp_valid_o && rsp_ready_i) begin
               state_d = IDLE;
            end else if (refill_start_o) begin
               state_d = REFILL;
            end
         end
         REFILL: begin
            if (refill_done_i) begin
               state_d = REPLAY;
            end
         end
         REPLAY: state_d = LOOKUP;
         default: state_d = INIT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= INIT;
         init_idx_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == INIT) begin
            init_idx_q <= init_idx_q + 1'b1;
         end
      end
   end

   // Request fields and miss context
   always_ff @(posedge clk) begin
      if (req_valid_i && req_ready_o) begin
         req_we_q <= req_we_i;
         req_addr_q <= req_addr_i;
         req_wdata_q <= req_wdata_i;
         req_bsel_q <= req_bsel_i;
      end
      if (refill_start_o) begin
         victim_q <= victim_i;
         saved_line_q <= tag_line_i;
      end
   end

   // Tag and data RAM writes
   always_comb begin
      tag_we_o = 1'b0;
      tag_waddr_o = req_index;
      tag_wdata_o = '0;
      data_we_o = '0;
      data_waddr_o = {req_index, req_addr_q[OFFSET_WIDTH-1:WORD_LSB]};
      data_wdata_o = merged_i;
      lru_access_o = '0;
      case (state_q)
         // Sweep clears one set per cycle
         INIT: begin
            tag_we_o = 1'b1;
            tag_waddr_o = init_idx_q;
         end
         // Whole set dropped on the handshake, LRU included
         IDLE: begin
            if (inv_valid_i) begin
               tag_we_o = 1'b1;
               tag_waddr_o = inv_index_i;
            end
         end
         LOOKUP: begin
            lru_access_o = way_hit_i;
            // Nothing changes until the response is taken
            if (hit_i && rsp_ready_i) begin
               tag_we_o = 1'b1;
               tag_wdata_o = tag_line_i;
               tag_wdata_o.lru = lru_next_i;
               if (req_we_q) begin
                  data_we_o = way_hit_i;
               end
            end
         end
         REFILL: begin
            lru_access_o = victim_q;
            data_we_o = beat_we_i ? victim_q : '0;
            data_waddr_o = {req_index, beat_word_i};
            data_wdata_o = beat_data_i;
            // Victim way gets the new tag with the last beat
            if (refill_done_i) begin
               tag_we_o = 1'b1;
               tag_wdata_o = saved_line_q;
               tag_wdata_o.lru = lru_next_i;
               for (int w = 0; w < NUM_WAYS; w++) begin
                  if (victim_q[w]) begin
                     tag_wdata_o.way[w].valid = 1'b1;
                     tag_wdata_o.way[w].tag = req_tag_o;
                  end
               end
            end
         end
         default: begin
         end
      endcase
   end

   a_rsp_held: assert property (@(posedge clk) disable iff (rst)
      rsp_valid_o && !rsp_ready_i |=> rsp_valid_o);

   // Tag RAM keeps showing the missed set while the line comes in
   a_fill_set_held: assert property (@(posedge clk) disable iff (rst)
      state_q == REFILL |-> lru_history_i == saved_line_q.lru);

endmodule

//--- logic/dcache_top.sv
module dcache_top (
   input  logic                                      clk,
   input  logic                                      rst,
   input  logic                                      req_valid_i,
   output logic                                      req_ready_o,
   input  logic                                      req_we_i,
   input  logic [dcache_cfg_pkg::ADDR_WIDTH-1:0]     req_addr_i,
   input  dcache_types_pkg::word_t                   req_wdata_i,
   input  logic [dcache_cfg_pkg::BYTES_PER_WORD-1:0] req_bsel_i,
   output logic                                      rsp_valid_o,
   input  logic                                      rsp_ready_i,
   output dcache_types_pkg::word_t                   rsp_rdata_o,
   output logic                                      rsp_hit_o,
   input  logic                                      inv_valid_i,
   output logic                                      inv_ready_o,
   input  logic [dcache_cfg_pkg::INDEX_WIDTH-1:0]    inv_index_i,
   output logic                                      mem_req_valid_o,
   input  logic                                      mem_req_ready_i,
   output logic [dcache_cfg_pkg::ADDR_WIDTH-1:0]     mem_req_addr_o,
   input  logic                                      mem_rvalid_i,
   input  dcache_types_pkg::word_t                   mem_rdata_i
);

   import dcache_cfg_pkg::*;
   import dcache_types_pkg::*;

   way_mask_t                 way_hit;
   way_mask_t                 victim;
   way_mask_t                 lru_access;
   way_mask_t                 data_we;
   tag_line_t                 tag_rdata;
   tag_line_t                 tag_wdata;
   logic                      tag_we;
   logic [INDEX_WIDTH-1:0]    tag_raddr;
   logic [INDEX_WIDTH-1:0]    tag_waddr;
   logic [LRU_WIDTH-1:0]      lru_next;
   logic [DATA_ADDR_WIDTH-1:0] data_raddr;
   logic [DATA_ADDR_WIDTH-1:0] data_waddr;
   word_t                     data_wdata;
   word_t                     merged;
   word_t [NUM_WAYS-1:0]      way_rdata;
   logic                      refill_start;
   logic [ADDR_WIDTH-1:0]     refill_line_addr;
   logic                      beat_we;
   logic [WORD_SEL_WIDTH-1:0] beat_word;
   word_t                     beat_data;
   logic                      refill_done;
   logic [TAG_WIDTH-1:0]      req_tag;
   word_t                     req_wdata;
   logic [BYTES_PER_WORD-1:0] req_bsel;

   dcache_ctrl u_ctrl (
      .clk, .rst,
      .req_valid_i, .req_ready_o, .req_we_i, .req_addr_i, .req_wdata_i, .req_bsel_i,
      .inv_valid_i, .inv_ready_o, .inv_index_i,
      .rsp_valid_o, .rsp_ready_i,
      .hit_i(rsp_hit_o), .way_hit_i(way_hit), .victim_i(victim), .tag_line_i(tag_rdata),
      .lru_history_i(tag_rdata.lru), .lru_next_i(lru_next), .lru_access_o(lru_access),
      .tag_raddr_o(tag_raddr), .tag_we_o(tag_we), .tag_waddr_o(tag_waddr),
      .tag_wdata_o(tag_wdata),
      .data_raddr_o(data_raddr), .data_we_o(data_we), .data_waddr_o(data_waddr),
      .data_wdata_o(data_wdata), .merged_i(merged),
      .refill_start_o(refill_start), .refill_line_addr_o(refill_line_addr),
      .beat_we_i(beat_we), .beat_word_i(beat_word), .beat_data_i(beat_data),
      .refill_done_i(refill_done),
      .req_tag_o(req_tag), .req_wdata_o(req_wdata), .req_bsel_o(req_bsel)
   );

   dcache_lookup u_lookup (
      .tag_line_i(tag_rdata), .way_rdata_i(way_rdata),
      .req_tag_i(req_tag), .req_wdata_i(req_wdata), .req_bsel_i(req_bsel),
      .hit_o(rsp_hit_o), .way_hit_o(way_hit), .rdata_o(rsp_rdata_o), .merged_o(merged)
   );

   dcache_lru u_lru (
      .history_i(tag_rdata.lru), .access_i(lru_access),
      .history_o(lru_next), .victim_o(victim)
   );

   dcache_refill u_refill (
      .clk, .rst,
      .start_i(refill_start), .line_addr_i(refill_line_addr),
      .mem_req_valid_o, .mem_req_ready_i, .mem_req_addr_o, .mem_rvalid_i, .mem_rdata_i,
      .beat_we_o(beat_we), .beat_word_o(beat_word), .beat_data_o(beat_data),
      .done_o(refill_done)
   );

   // One tag line per set
   dcache_sdp_ram #(.payload_t(tag_line_t), .DEPTH_LOG2(INDEX_WIDTH)) u_tag_ram (
      .clk, .we_i(tag_we), .waddr_i(tag_waddr), .wdata_i(tag_wdata),
      .raddr_i(tag_raddr), .rdata_o(tag_rdata)
   );

   // One word-wide data RAM per way
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_sdp_ram #(.payload_t(word_t), .DEPTH_LOG2(DATA_ADDR_WIDTH)) u_data_ram (
         .clk, .we_i(data_we[w]), .waddr_i(data_waddr), .wdata_i(data_wdata),
         .raddr_i(data_raddr), .rdata_o(way_rdata[w])
      );
   end

endmodule

//--- tb/dcache_mem_model.sv
module dcache_mem_model (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  mem_req_valid_i,
   output logic                                  mem_req_ready_o,
   input  logic [dcache_cfg_pkg::ADDR_WIDTH-1:0] mem_req_addr_i,
   output logic                                  mem_rvalid_o,
   output logic [dcache_cfg_pkg::DATA_WIDTH-1:0] mem_rdata_o,
   output logic [31:0]                           fill_count_o,
   output logic [dcache_cfg_pkg::ADDR_WIDTH-1:0] last_addr_o
);

   timeunit 1ns;
   timeprecision 100ps;

   import dcache_cfg_pkg::*;

   // Memory content never changes
   function automatic logic [DATA_WIDTH-1:0] word_at(input logic [ADDR_WIDTH-1:0] addr);
      return addr ^ 32'hc0de_0000;
   endfunction

   // Outputs move 2 ns after the rising edge, inputs are read there too
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   initial begin
      logic [ADDR_WIDTH-1:0] line;
      int unsigned           gap;
      mem_req_ready_o = 1'b0;
      mem_rvalid_o = 1'b0;
      mem_rdata_o = '0;
      fill_count_o = '0;
      last_addr_o = '0;
      forever begin
         next_cycle();
         if (!rst && mem_req_valid_i) begin
            line = mem_req_addr_i;
            // Random delay before the request is taken
            gap = $urandom_range(3, 0);
            repeat (gap) next_cycle();
            mem_req_ready_o = 1'b1;
            next_cycle();
            mem_req_ready_o = 1'b0;
            fill_count_o = fill_count_o + 1;
            last_addr_o = line;
            // Beats in word order from offset 0, random gaps between them
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
               gap = $urandom_range(2, 0);
               repeat (gap) next_cycle();
               mem_rvalid_o = 1'b1;
               mem_rdata_o = word_at(line + ADDR_WIDTH'(BYTES_PER_WORD * k));
               next_cycle();
               mem_rvalid_o = 1'b0;
            end
         end
      end
   end

endmodule

//--- tb/dcache_tb.sv
module dcache_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import dcache_cfg_pkg::*;

   typedef enum logic [1:0] {
      OP_READ,
      OP_WRITE,
      OP_INV
   } op_e;

   // exp_hit means the line is present, so a read needs no refill
   typedef struct packed {
      op_e                       op;
      logic [ADDR_WIDTH-1:0]     addr;
      logic [DATA_WIDTH-1:0]     wdata;
      logic [BYTES_PER_WORD-1:0] bsel;
      logic                      exp_hit;
      logic [DATA_WIDTH-1:0]     exp_rdata;
   } entry_t;

   localparam int NUM_ENTRIES = 25;
   localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 64 + 100;

   // Memory word at A is A ^ c0de0000; set index is addr[7:4]
   localparam entry_t STIMULUS [NUM_ENTRIES] = '{
      // First read misses, same line then hits
      '{OP_READ,  32'h0000_1000, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_1000},
      '{OP_READ,  32'h0000_1000, 32'h0000_0000, 4'b0000, 1'b1, 32'hc0de_1000},
      '{OP_READ,  32'h0000_100c, 32'h0000_0000, 4'b0000, 1'b1, 32'hc0de_100c},
      '{OP_READ,  32'h0000_2044, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_2044},
      '{OP_READ,  32'h0000_2048, 32'h0000_0000, 4'b0000, 1'b1, 32'hc0de_2048},
      // Partial and full write hits, then read back merged words
      '{OP_WRITE, 32'h0000_1004, 32'h1122_3344, 4'b0101, 1'b1, 32'h0000_0000},
      '{OP_READ,  32'h0000_1004, 32'h0000_0000, 4'b0000, 1'b1, 32'hc022_1044},
      '{OP_WRITE, 32'h0000_1008, 32'hdead_beef, 4'b1111, 1'b1, 32'h0000_0000},
      '{OP_READ,  32'h0000_1008, 32'h0000_0000, 4'b0000, 1'b1, 32'hdead_beef},
      // Write miss leaves memory data in place
      '{OP_WRITE, 32'h0000_5050, 32'hffff_ffff, 4'b1111, 1'b0, 32'h0000_0000},
      '{OP_READ,  32'h0000_5050, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_5050},
      // Set 3 with A, B, C
      '{OP_READ,  32'h0000_a030, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_a030},
      '{OP_READ,  32'h0000_b034, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_b034},
      '{OP_READ,  32'h0000_a030, 32'h0000_0000, 4'b0000, 1'b1, 32'hc0de_a030},
      '{OP_READ,  32'h0000_c038, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_c038},
      '{OP_READ,  32'h0000_a03c, 32'h0000_0000, 4'b0000, 1'b1, 32'hc0de_a03c},
      '{OP_READ,  32'h0000_b034, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_b034},
      '{OP_READ,  32'h0000_c038, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_c038},
      // Invalidate drops the written line of set 0
      '{OP_INV,   32'h0000_0000, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000},
      '{OP_READ,  32'h0000_1004, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_1004},
      '{OP_READ,  32'h0000_1008, 32'h0000_0000, 4'b0000, 1'b1, 32'hc0de_1008},
      '{OP_INV,   32'h0000_0040, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000},
      '{OP_READ,  32'h0000_2040, 32'h0000_0000, 4'b0000, 1'b0, 32'hc0de_2040},
      // A was evicted by C, B still sits in way 1
      '{OP_WRITE, 32'h0000_a030, 32'h0123_4567, 4'b1111, 1'b0, 32'h0000_0000},
      '{OP_READ,  32'h0000_b03c, 32'h0000_0000, 4'b0000, 1'b1, 32'hc0de_b03c}
   };

   logic                      clk;
   logic                      rst;
   logic                      req_valid;
   logic                      req_ready;
   logic                      req_we;
   logic [ADDR_WIDTH-1:0]     req_addr;
   logic [DATA_WIDTH-1:0]     req_wdata;
   logic [BYTES_PER_WORD-1:0] req_bsel;
   logic                      rsp_valid;
   logic                      rsp_ready;
   logic [DATA_WIDTH-1:0]     rsp_rdata;
   logic                      rsp_hit;
   logic                      inv_valid;
   logic                      inv_ready;
   logic [INDEX_WIDTH-1:0]    inv_index;
   logic                      mem_req_valid;
   logic                      mem_req_ready;
   logic [ADDR_WIDTH-1:0]     mem_req_addr;
   logic                      mem_rvalid;
   logic [DATA_WIDTH-1:0]     mem_rdata;
   logic [31:0]               fill_count;
   logic [ADDR_WIDTH-1:0]     last_fill_addr;
   int                        errors = 0;
   int                        cycle_count = 0;

   dcache_top u_dut (
      .clk, .rst,
      .req_valid_i(req_valid), .req_ready_o(req_ready), .req_we_i(req_we),
      .req_addr_i(req_addr), .req_wdata_i(req_wdata), .req_bsel_i(req_bsel),
      .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_rdata_o(rsp_rdata),
      .rsp_hit_o(rsp_hit),
      .inv_valid_i(inv_valid), .inv_ready_o(inv_ready), .inv_index_i(inv_index),
      .mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready),
      .mem_req_addr_o(mem_req_addr), .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
   );

   dcache_mem_model u_mem (
      .clk, .rst,
      .mem_req_valid_i(mem_req_valid), .mem_req_ready_o(mem_req_ready),
      .mem_req_addr_i(mem_req_addr), .mem_rvalid_o(mem_rvalid), .mem_rdata_o(mem_rdata),
      .fill_count_o(fill_count), .last_addr_o(last_fill_addr)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Run limit
   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Finished with errors");
      $fatal(1, "Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         errors++;
         $display("error at %0d ns: %s: got %h, expected %h", $time, what, actual, expected);
         $display("Finished with errors");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   // Drive and sample 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // Outputs idle after reset, then both readies stay low for one cycle per set
   task automatic check_init_sweep();
      int low_cycles;
      low_cycles = 0;
      check_value(rsp_valid, 1'b0, "rsp_valid after reset");
      check_value(mem_req_valid, 1'b0, "mem_req_valid after reset");
      while (!req_ready && low_cycles <= NUM_SETS) begin
         check_value(inv_ready, 1'b0, "inv_ready during init sweep");
         low_cycles++;
         next_cycle();
      end
      check_value(low_cycles, NUM_SETS, "init sweep length");
      check_value(inv_ready, 1'b1, "inv_ready after init sweep");
   endtask

   task automatic invalidate_set(input logic [INDEX_WIDTH-1:0] index);
      inv_valid = 1'b1;
      inv_index = index;
      while (!inv_ready) next_cycle();
      next_cycle();
      inv_valid = 1'b0;
   endtask

   task automatic run_request(input entry_t e, input int idx);
      logic [31:0] fills_before;
      logic        is_write;
      logic        expect_fill;
      int          wait_cycles;
      bit          done;
      is_write = (e.op == OP_WRITE);
      expect_fill = !is_write && !e.exp_hit;
      fills_before = fill_count;
      wait_cycles = 0;
      done = 1'b0;
      req_valid = 1'b1;
      req_we = is_write;
      req_addr = e.addr;
      req_wdata = e.wdata;
      req_bsel = e.bsel;
      while (!req_ready) next_cycle();
      next_cycle();
      req_valid = 1'b0;
      // Random back-pressure; fields are checked on every valid cycle
      while (!done) begin
         rsp_ready = ($urandom_range(1, 0) == 1);
         if (rsp_valid) begin
            // A read miss answers after replay, so reads always report a hit
            check_value(rsp_hit, is_write ? e.exp_hit : 1'b1,
                        $sformatf("entry %0d hit flag", idx));
            if (!is_write) begin
               check_value(rsp_rdata, e.exp_rdata, $sformatf("entry %0d read data", idx));
            end
            done = rsp_ready;
         end else begin
            wait_cycles++;
         end
         next_cycle();
      end
      rsp_ready = 1'b0;
      check_value(fill_count - fills_before, expect_fill ? 1 : 0,
                  $sformatf("entry %0d line fills", idx));
      if (expect_fill) begin
         check_value(last_fill_addr, {e.addr[ADDR_WIDTH-1:OFFSET_WIDTH], 4'h0},
                     $sformatf("entry %0d fill address", idx));
      end else begin
         // Hits and write misses answer one cycle after the handshake
         check_value(wait_cycles, 0, $sformatf("entry %0d response latency", idx));
      end
   endtask

   initial begin
      void'($urandom(32'h7b1c8c3d));
      rst = 1'b1;
      req_valid = 1'b0;
      req_we = 1'b0;
      req_addr = '0;
      req_wdata = '0;
      req_bsel = '0;
      rsp_ready = 1'b0;
      inv_valid = 1'b0;
      inv_index = '0;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      // Tag clear sweep first, then the table
      check_init_sweep();
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         if (STIMULUS[i].op == OP_INV) begin
            invalidate_set(STIMULUS[i].addr[TAG_LSB-1:OFFSET_WIDTH]);
         end else begin
            run_request(STIMULUS[i], i);
         end
      end
      if (errors == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("Finished with errors");
         $fatal(1, "%0d mismatches found", errors);
      end
   end

endmodule

//--- compile.f
logic/dcache_cfg_pkg.sv
logic/dcache_types_pkg.sv
logic/dcache_sdp_ram.sv
logic/dcache_lookup.sv
logic/dcache_lru.sv
logic/dcache_refill.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

//--- Makefile
# Verilator build and run of the data cache testbench
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module dcache_tb -Mdir $(OBJ_DIR) -o dcache_tb -f compile.f
	./$(OBJ_DIR)/dcache_tb

clean:
	rm -rf $(OBJ_DIR)
